// ==== filelist.f ====
+incdir+verif
rtl/dispatch_pkg.sv
rtl/class_rank.sv
rtl/port_fill.sv
rtl/port_rotate.sv
rtl/dispatch_distrib.sv
verif/tb_dispatch.sv

// ==== run.sh ====
#!/bin/sh
# build and run the distributor testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps -f filelist.f \
  --top-module tb_dispatch -o tb_dispatch \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_dispatch)
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1

// ==== verif/dispatch_ref.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// golden model of the distributor
// include inside a module compiled after dispatch_pkg
// ~~~~~~~~~~~~~~~~~~~~
`ifndef DISPATCH_REF_SVH
`define DISPATCH_REF_SVH

// one 32 bit xorshift step
function automatic logic [31:0] xorshift32(logic [31:0] state);
  logic [31:0] x;
  x = state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// one-hot of the rank-th set slot or the empty code
function automatic dispatch_pkg::port_sel_t ref_nth(dispatch_pkg::slot_mask_t mask, int rank);
  int seen;
  seen = 0;
  for (int k = 0; k < dispatch_pkg::num_slots; k++) begin
    if (mask[k]) begin
      if (seen == rank) begin
        return dispatch_pkg::port_sel_t'(1) << k;
      end
      seen++;
    end
  end
  return dispatch_pkg::port_empty;
endfunction

// unrotated select of port p
function automatic dispatch_pkg::port_sel_t ref_fill(
  dispatch_pkg::slot_mask_t store,
  dispatch_pkg::slot_mask_t load,
  dispatch_pkg::slot_mask_t alu,
  dispatch_pkg::slot_mask_t shift,
  int                       p
);
  int ns;
  int nl;
  int na;
  int nsh;
  int a0;
  ns  = $countones(store);
  nl  = $countones(load);
  na  = $countones(alu);
  nsh = $countones(shift);
  a0  = (ns + nl > 3) ? ns + nl : 3;
  if (p < 3 && p < ns) return ref_nth(store, p);
  if (p < 6 && p >= ns && p - ns < nl) return ref_nth(load, p - ns);
  if (p >= 6 && 8 - p < nsh) return ref_nth(shift, 8 - p);
  if (p >= a0 && p - a0 < na) return ref_nth(alu, p - a0);
  return dispatch_pkg::port_empty;
endfunction

// expected pos[p] for the given rotation state
function automatic dispatch_pkg::port_sel_t ref_pos(
  dispatch_pkg::slot_mask_t store,
  dispatch_pkg::slot_mask_t load,
  dispatch_pkg::slot_mask_t alu,
  dispatch_pkg::slot_mask_t shift,
  int                       load_rot,
  int                       shift_rot,
  int                       p
);
  int base;
  int r;
  base = (p / 3) * 3;
  r    = (base == 6) ? shift_rot : load_rot;
  return ref_fill(store, load, alu, shift, base + (p - base + r) % 3);
endfunction

function automatic int ref_load_rot_next(int rot, dispatch_pkg::slot_mask_t load);
  return (rot + $countones(load)) % 3;
endfunction

// at most three shifts count toward the rotation
function automatic int ref_shift_rot_next(int rot, dispatch_pkg::slot_mask_t shift);
  int nsh;
  nsh = $countones(shift);
  if (nsh > 3) nsh = 3;
  return (rot + nsh) % 3;
endfunction

`endif

// ==== verif/tb_dispatch.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// self-checking testbench for the ten slot distributor
// outputs are compared mid cycle against the model
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_dispatch;
  import dispatch_pkg::*;

  `include "dispatch_ref.svh"

  localparam int num_random      = 2000;
  localparam int directed_cycles = 40;
  localparam int test_cycles     = 16 + directed_cycles + num_random;

  localparam slot_mask_t none = '0;

  logic       clk = 1'b0;
  logic       rst;
  logic       stall;
  slot_mask_t store;
  slot_mask_t load;
  slot_mask_t alu;
  slot_mask_t shift;
  port_sel_t  pos [num_ports];

  port_sel_t   exp_pos [num_ports];
  int          load_rot;
  int          shift_rot;
  int          cmp_errors;
  int          dir_errors;
  logic [31:0] rng;

  dispatch_distrib i_dut (
    .clk   (clk),
    .rst   (rst),
    .stall (stall),
    .store (store),
    .load  (load),
    .alu   (alu),
    .shift (shift),
    .pos   (pos)
  );

  always #50 clk = ~clk;

  // model registers follow the DUT, inputs and outputs are both stable at negedge
  always @(negedge clk) begin
    for (int p = 0; p < num_ports; p++) begin
      assert (pos[p] === exp_pos[p]) else begin
        cmp_errors++;
        $display("Error at %0t ns: pos[%0d] expected %h, actual %h",
                 $time, p, exp_pos[p], pos[p]);
      end
    end
    if (rst) begin
      for (int p = 0; p < num_ports; p++) begin
        exp_pos[p] = port_empty;
      end
      load_rot  = 0;
      shift_rot = 0;
    end else if (!stall) begin
      // old rotation values apply to this bundle
      for (int p = 0; p < num_ports; p++) begin
        exp_pos[p] = ref_pos(store, load, alu, shift, load_rot, shift_rot, p);
      end
      load_rot  = ref_load_rot_next(load_rot, load);
      shift_rot = ref_shift_rot_next(shift_rot, shift);
    end
  end

  task automatic drive_bundle(
    input slot_mask_t st,
    input slot_mask_t ld,
    input slot_mask_t al,
    input slot_mask_t sh,
    input logic       stl
  );
    @(posedge clk);
    #1;
    store = st;
    load  = ld;
    alu   = al;
    shift = sh;
    stall = stl;
  endtask

  task automatic expect_port(input int p, input port_sel_t want);
    assert (pos[p] === want) else begin
      dir_errors++;
      $display("Error at %0t ns: pos[%0d] expected %h, actual %h", $time, p, want, pos[p]);
    end
  endtask

  // loads in slots 0 and 1 and a shift in slot 2
  // load rotation 0 leaves ports 0 to 5 alone and shift rotation 2 moves port 8 to port 6
  task automatic expect_stall_bundle;
    expect_port(0, 10'b0000000001);
    expect_port(1, 10'b0000000010);
    expect_port(2, port_empty);
    expect_port(3, port_empty);
    expect_port(4, port_empty);
    expect_port(5, port_empty);
    expect_port(6, 10'b0000000100);
    expect_port(7, port_empty);
    expect_port(8, port_empty);
  endtask

  // three random bits per slot pick its class, so classes never overlap
  task automatic random_bundle;
    logic [31:0] r;
    slot_mask_t  st;
    slot_mask_t  ld;
    slot_mask_t  al;
    slot_mask_t  sh;
    logic        stl;
    rng = xorshift32(rng);
    r   = rng;
    st  = '0;
    ld  = '0;
    al  = '0;
    sh  = '0;
    for (int k = 0; k < num_slots; k++) begin
      case (r[3*k +: 3])
        3'd0: st[k] = 1'b1;
        3'd1: ld[k] = 1'b1;
        3'd2, 3'd3: al[k] = 1'b1;
        3'd4: sh[k] = 1'b1;
        default: ;
      endcase
    end
    rng = xorshift32(rng);
    stl = (rng[1:0] == 2'd0);
    drive_bundle(st, ld, al, sh, stl);
  endtask

  initial begin
    rst        = 1'b1;
    stall      = 1'b0;
    store      = none;
    load       = none;
    alu        = none;
    shift      = none;
    rng        = 32'h94d9_5845;
    cmp_errors = 0;
    dir_errors = 0;
    load_rot   = 0;
    shift_rot  = 0;
    for (int p = 0; p < num_ports; p++) begin
      exp_pos[p] = port_empty;
    end
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    // nothing issued yet
    @(negedge clk);
    for (int p = 0; p < num_ports; p++) begin
      expect_port(p, port_empty);
    end

    // two stores and five loads, rotation still at 0
    drive_bundle(10'b0000010010, 10'b0010101101, none, none, 1'b0);
    drive_bundle(none, none, none, none, 1'b0);
    @(negedge clk);
    expect_port(0, 10'b0000000010);
    expect_port(1, 10'b0000010000);
    expect_port(2, 10'b0000000001);
    expect_port(3, 10'b0000000100);
    expect_port(4, 10'b0000001000);
    expect_port(5, 10'b0000100000);
    expect_port(6, port_empty);
    expect_port(7, port_empty);
    expect_port(8, port_empty);

    // alu placement and shift fill, with ops dropped
    drive_bundle(10'b0000000001, 10'b0000000010, 10'b0111110000, 10'b1000000100, 1'b0);
    drive_bundle(10'b0000000111, 10'b0000111000, 10'b1111000000, none, 1'b0);
    drive_bundle(10'b0000001111, 10'b0000110000, 10'b0011000000, 10'b1100000000, 1'b0);
    drive_bundle(none, none, 10'b0000001111, 10'b1111110000, 1'b0);

    // load and shift counts that move the rotations
    drive_bundle(none, 10'b0000000001, none, 10'b0000000010, 1'b0);
    drive_bundle(none, 10'b0000000011, 10'b0000000100, 10'b0000011000, 1'b0);
    drive_bundle(10'b0000000001, 10'b0000011110, none, 10'b1000000000, 1'b0);
    drive_bundle(none, 10'b0000000111, 10'b0000111000, none, 1'b0);

    // stall freezes pos while the masks keep changing
    drive_bundle(none, 10'b0000000011, none, 10'b0000000100, 1'b0);
    drive_bundle(10'b0000000001, 10'b0000000010, 10'b0000000100, 10'b0000001000, 1'b1);
    @(negedge clk);
    expect_stall_bundle();
    drive_bundle(none, 10'b0000001111, 10'b0000110000, 10'b1100000000, 1'b1);
    drive_bundle(10'b0000000011, 10'b0000000100, none, 10'b0000011000, 1'b1);
    drive_bundle(none, 10'b0000000001, 10'b0000000010, none, 1'b1);
    @(negedge clk);
    expect_stall_bundle();
    drive_bundle(none, 10'b0000000001, 10'b0000000110, 10'b0000001000, 1'b0);
    drive_bundle(none, none, none, none, 1'b0);

    repeat (num_random) random_bundle();

    drive_bundle(none, none, none, none, 1'b0);
    @(negedge clk);
    @(negedge clk);
    #1;
    $display("errors: compare %0d, directed %0d", cmp_errors, dir_errors);
    if (cmp_errors + dir_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (test_cycles + 50) @(posedge clk);
    $display("timeout: the test did not finish within %0d cycles", test_cycles + 50);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== rtl/dispatch_distrib.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// class masks must not overlap
// pos follows the masks one cycle later
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dispatch_distrib (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     stall,
  input  dispatch_pkg::slot_mask_t store,
  input  dispatch_pkg::slot_mask_t load,
  input  dispatch_pkg::slot_mask_t alu,
  input  dispatch_pkg::slot_mask_t shift,
  output dispatch_pkg::port_sel_t  pos [dispatch_pkg::num_ports]
);
  import dispatch_pkg::*;

  slot_count_t store_cnt;
  slot_count_t load_cnt;
  slot_count_t alu_cnt;
  slot_count_t shift_cnt;

  port_sel_t store_nth [max_rank];
  port_sel_t load_nth [max_rank];
  port_sel_t alu_nth [max_rank];
  port_sel_t shift_nth [max_rank];

  // combinational assignment before rotation
  port_sel_t fill [num_ports];

  class_rank i_store_rank (
    .mask  (store),
    .count (store_cnt),
    .nth   (store_nth)
  );

  class_rank i_load_rank (
    .mask  (load),
    .count (load_cnt),
    .nth   (load_nth)
  );

  class_rank i_alu_rank (
    .mask  (alu),
    .count (alu_cnt),
    .nth   (alu_nth)
  );

  class_rank i_shift_rank (
    .mask  (shift),
    .count (shift_cnt),
    .nth   (shift_nth)
  );

  port_fill i_port_fill (
    .store_cnt (store_cnt),
    .load_cnt  (load_cnt),
    .alu_cnt   (alu_cnt),
    .shift_cnt (shift_cnt),
    .store_nth (store_nth),
    .load_nth  (load_nth),
    .alu_nth   (alu_nth),
    .shift_nth (shift_nth),
    .fill      (fill)
  );

  port_rotate i_port_rotate (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .fill      (fill),
    .load_cnt  (load_cnt),
    .shift_cnt (shift_cnt),
    .pos       (pos)
  );

endmodule

// ==== rtl/port_rotate.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// registered outputs with one cycle latency
// stall freezes pos and both rotations
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module port_rotate (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      stall,
  input  dispatch_pkg::port_sel_t   fill [dispatch_pkg::num_ports],
  input  dispatch_pkg::slot_count_t load_cnt,
  input  dispatch_pkg::slot_count_t shift_cnt,
  output dispatch_pkg::port_sel_t   pos [dispatch_pkg::num_ports]
);
  import dispatch_pkg::*;

  localparam slot_count_t triple = slot_count_t'(3);

  rot_t      load_rot;
  rot_t      shift_rot;
  rot_t      load_adv;
  rot_t      shift_adv;
  rot_t      load_rot_nxt;
  rot_t      shift_rot_nxt;
  port_sel_t rotated [num_ports];

  function automatic rot_t add_mod3(rot_t a, rot_t b);
    logic [2:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    return (sum >= 3'd3) ? rot_t'(sum - 3'd3) : rot_t'(sum);
  endfunction

  // lane i of a triple takes unrotated lane (i + r) mod 3
  function automatic port_sel_t pick3(
    port_sel_t s0,
    port_sel_t s1,
    port_sel_t s2,
    rot_t      r
  );
    return (r == 2'd0) ? s0 : (r == 2'd1) ? s1 : s2;
  endfunction

  // loads move the load triples by their count
  assign load_adv = rot_t'(load_cnt % triple);

  // at most three shifts issue so the count saturates first
  assign shift_adv = (shift_cnt >= triple) ? 2'd0 : shift_cnt[1:0];

  assign load_rot_nxt  = add_mod3(load_rot, load_adv);
  assign shift_rot_nxt = add_mod3(shift_rot, shift_adv);

  // triples 0 and 1 follow the loads, triple 2 the shifts
  for (genvar t = 0; t < 3; t++) begin : g_triple
    rot_t r;

    assign r = (t == 2) ? shift_rot : load_rot;

    for (genvar i = 0; i < 3; i++) begin : g_lane
      assign rotated[3*t+i] = pick3(fill[3*t+i],
                                    fill[3*t+(i+1)%3],
                                    fill[3*t+(i+2)%3],
                                    r);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      load_rot  <= '0;
      shift_rot <= '0;
      for (int p = 0; p < num_ports; p++) begin
        pos[p] <= port_empty;
      end
    end else if (!stall) begin
      load_rot  <= load_rot_nxt;
      shift_rot <= shift_rot_nxt;
      for (int p = 0; p < num_ports; p++) begin
        pos[p] <= rotated[p];
      end
    end
  end

endmodule

// ==== rtl/port_fill.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// unrotated port assignment for one bundle
// ops that find no port are dropped without notice
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module port_fill (
  input  dispatch_pkg::slot_count_t store_cnt,
  input  dispatch_pkg::slot_count_t load_cnt,
  input  dispatch_pkg::slot_count_t alu_cnt,
  input  dispatch_pkg::slot_count_t shift_cnt,
  input  dispatch_pkg::port_sel_t   store_nth [dispatch_pkg::max_rank],
  input  dispatch_pkg::port_sel_t   load_nth [dispatch_pkg::max_rank],
  input  dispatch_pkg::port_sel_t   alu_nth [dispatch_pkg::max_rank],
  input  dispatch_pkg::port_sel_t   shift_nth [dispatch_pkg::max_rank],
  output dispatch_pkg::port_sel_t   fill [dispatch_pkg::num_ports]
);
  import dispatch_pkg::*;

  typedef logic [$clog2(max_rank)-1:0] rank_idx_t;

  // alu never starts below port 3
  localparam slot_count_t alu_floor = slot_count_t'(3);

  slot_count_t ldst_cnt;
  slot_count_t alu_base;

  // port sits inside the run [base, base+cnt)
  function automatic logic rank_ok(
    slot_count_t port_num,
    slot_count_t base,
    slot_count_t cnt
  );
    slot_count_t diff;
    diff = port_num - base;
    return (port_num >= base) && (diff < cnt);
  endfunction

  // only meaningful when rank_ok holds, the offset is then below max_rank
  function automatic rank_idx_t rank_of(slot_count_t port_num, slot_count_t base);
    slot_count_t diff;
    diff = port_num - base;
    return diff[$clog2(max_rank)-1:0];
  endfunction

  // memory ops pack from port 0, alu follows them
  assign ldst_cnt = store_cnt + load_cnt;
  assign alu_base = (ldst_cnt > alu_floor) ? ldst_cnt : alu_floor;

  for (genvar p = 0; p < num_ports; p++) begin : g_port
    localparam slot_count_t port_num = slot_count_t'(p);

    if (p < 3) begin : g_mem
      // stores first then the head of the loads
      assign fill[p] = (port_num < store_cnt) ? store_nth[p] :
                       rank_ok(port_num, store_cnt, load_cnt) ?
                         load_nth[rank_of(port_num, store_cnt)] :
                       port_empty;

    end else if (p < 6) begin : g_mid
      // load tail then alu
      assign fill[p] = rank_ok(port_num, store_cnt, load_cnt) ?
                         load_nth[rank_of(port_num, store_cnt)] :
                       rank_ok(port_num, alu_base, alu_cnt) ?
                         alu_nth[rank_of(port_num, alu_base)] :
                       port_empty;

    end else begin : g_shift
      // shifts fill downward from the last port
      localparam int shift_rank = num_ports - 1 - p;

      assign fill[p] = (slot_count_t'(shift_rank) < shift_cnt) ? shift_nth[shift_rank] :
                       rank_ok(port_num, alu_base, alu_cnt) ?
                         alu_nth[rank_of(port_num, alu_base)] :
                       port_empty;
    end
  end

endmodule

// ==== rtl/class_rank.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// combinational ranker for one instruction class
// ranks past max_rank are not produced
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module class_rank (
  input  dispatch_pkg::slot_mask_t  mask,
  output dispatch_pkg::slot_count_t count,
  output dispatch_pkg::port_sel_t   nth [dispatch_pkg::max_rank]
);
  import dispatch_pkg::*;

  // pre_cnt[k] counts the set slots among 0..k
  slot_count_t pre_cnt [num_slots];

  for (genvar k = 0; k < num_slots; k++) begin : g_prefix
    assign pre_cnt[k] = slot_count_t'($countones(mask[k:0]));
  end

  assign count = pre_cnt[num_slots-1];

  // slot k is rank j when it is set and its prefix count reaches j+1 there
  for (genvar j = 0; j < max_rank; j++) begin : g_rank
    localparam slot_count_t rank_cnt = slot_count_t'(j + 1);

    port_sel_t hit;

    for (genvar k = 0; k < num_slots; k++) begin : g_slot
      assign hit[k] = mask[k] && (pre_cnt[k] == rank_cnt);
    end

    // no j-th op in this bundle
    assign nth[j] = (count >= rank_cnt) ? hit : port_empty;
  end

endmodule

// ==== rtl/dispatch_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// fixed ten slot bundle and nine execution ports
// the RTL is only written for these sizes
// ~~~~~~~~~~~~~~~~~~~~

package dispatch_pkg;

  // bundle and port geometry
  localparam int num_slots = 10;
  localparam int num_ports = 9;

  // highest rank any port ever asks a class for
  localparam int max_rank = 6;

  // one bit per bundle slot
  typedef logic [num_slots-1:0] slot_mask_t;

  // one-hot slot select of a port
  typedef logic [num_slots-1:0] port_sel_t;

  // population count of a class mask, 0 to 10
  typedef logic [3:0] slot_count_t;

  // triple rotation amount, 0 to 2
  typedef logic [1:0] rot_t;

  // all ones marks a port with nothing issued
  localparam port_sel_t port_empty = '1;

endpackage
